//--- common/fetch_pkg.sv
package fetch_pkg;

  // ====================
  // datapath widths
  // ====================

  // pc and bus address
  localparam int ADDR_W = 32;

  // one cache line, also the width of a read data beat
  localparam int LINE_W = 128;

  // one rv32 instruction
  localparam int INST_W = 32;

  // byte offset bits inside a line, the tag sits above them
  localparam int LINE_OFF_W = 4;

  // ====================
  // line store geometry
  // ====================

  // lines held by the fetch buffer
  localparam int FIFO_DEPTH = 4;

  // two index bits plus the wrap bit
  localparam int FIFO_PTR_W = 3;

  // first fetch address after reset
  localparam logic [ADDR_W-1:0] RESET_PC = 32'h8000_0000;

  // ====================
  // read bus states
  // ====================

  // single outstanding read, address beat then data beat
  typedef enum logic {
    BUS_IDLE,
    BUS_WAIT_DATA
  } bus_state_e;

endpackage

//--- fetch_buffer/line_ram.sv
module line_ram (
  input  logic                             clk,
  input  logic                             we_i,
  input  logic [fetch_pkg::FIFO_PTR_W-2:0] waddr_i,
  input  logic [fetch_pkg::LINE_W-1:0]     wdata_i,
  input  logic [fetch_pkg::FIFO_PTR_W-2:0] raddr_i,
  output logic [fetch_pkg::LINE_W-1:0]     rdata_o
);
  import fetch_pkg::*;

  logic [LINE_W-1:0] mem [FIFO_DEPTH];
  logic              bypass;

  // line written on the clock edge
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // a line landing in the entry being read goes straight out
  assign bypass = we_i && (waddr_i == raddr_i);

  assign rdata_o = bypass ? wdata_i : mem[raddr_i];

endmodule

//--- fetch_buffer/fetch_buffer.sv
module fetch_buffer (
  input  logic                         clk,
  input  logic                         rst_n,

  // from the pc sequencer
  input  logic [fetch_pkg::ADDR_W-1:0] pc_i,
  input  logic                         jmp_flush_i,

  // read address channel
  input  logic                         ar_ready_i,
  output logic                         ar_valid_o,
  output logic [fetch_pkg::ADDR_W-1:0] ar_addr_o,

  // read data channel
  input  logic                         r_valid_i,
  input  logic [fetch_pkg::LINE_W-1:0] r_data_i,
  output logic                         r_ready_o,

  // instruction at pc_i
  output logic                         inst_valid_o,
  output logic [fetch_pkg::INST_W-1:0] inst_o
);
  import fetch_pkg::*;

  // line store pointers, msb is the wrap bit
  logic [FIFO_PTR_W-1:0] waddr_q;
  logic [FIFO_PTR_W-1:0] raddr_q;
  logic [FIFO_PTR_W-1:0] line_cnt;
  logic                  full;
  logic                  empty;

  // line tags, pc with the byte offset removed
  logic [ADDR_W-1:LINE_OFF_W] head_tag_q;
  logic [ADDR_W-1:LINE_OFF_W] pc_tag;
  logic [ADDR_W-1:LINE_OFF_W] req_tag;
  logic                       tag_hit;

  // bus side
  bus_state_e state_q;
  bus_state_e state_d;
  logic       fetch_en_q;
  logic       drop_q;
  logic       ar_fire;
  logic       r_fire;

  // store side
  logic              wr_en;
  logic              pop;
  logic [LINE_W-1:0] rd_line;

  // ====================
  // occupancy
  // ====================

  assign line_cnt = waddr_q - raddr_q;
  assign empty    = (raddr_q == waddr_q);

  // same index, opposite wrap bit
  assign full = (raddr_q == {~waddr_q[FIFO_PTR_W-1], waddr_q[FIFO_PTR_W-2:0]});

  // ====================
  // tag compare
  // ====================

  assign pc_tag  = pc_i[ADDR_W-1:LINE_OFF_W];
  assign tag_hit = (pc_tag == head_tag_q);

  // pc has walked past the oldest line
  assign pop = !empty && !tag_hit && !jmp_flush_i;

  // ====================
  // read bus fsm
  // ====================

  assign ar_fire = ar_valid_o && ar_ready_i;
  assign r_fire  = r_valid_i && r_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      BUS_IDLE: begin
        if (ar_fire) begin
          state_d = BUS_WAIT_DATA;
        end
      end
      BUS_WAIT_DATA: begin
        if (r_fire) begin
          state_d = BUS_IDLE;
        end
      end
      default: begin
        state_d = BUS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= BUS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // requests start one cycle after reset is released
  always_ff @(posedge clk) begin
    if (rst_n) begin
      fetch_en_q <= 1'b0;
    end else begin
      fetch_en_q <= 1'b1;
    end
  end

  // stale response still on its way when the flush hit
  always_ff @(posedge clk) begin
    if (rst_n) begin
      drop_q <= 1'b0;
    end else if (r_fire) begin
      drop_q <= 1'b0;
    end else if (jmp_flush_i && (state_q == BUS_WAIT_DATA)) begin
      drop_q <= 1'b1;
    end
  end

  // next line after the newest one buffered, or the target line on a flush
  assign req_tag = jmp_flush_i ? pc_tag :
                   head_tag_q + {{(ADDR_W - LINE_OFF_W - FIFO_PTR_W){1'b0}}, line_cnt};

  assign ar_valid_o = fetch_en_q && (state_q == BUS_IDLE) && !full;
  assign ar_addr_o  = {req_tag, {LINE_OFF_W{1'b0}}};
  assign r_ready_o  = (state_q == BUS_WAIT_DATA);

  // ====================
  // line store control
  // ====================

  // beats during or before a flush are thrown away
  assign wr_en = r_fire && !jmp_flush_i && !drop_q;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      waddr_q <= '0;
    end else if (wr_en) begin
      waddr_q <= waddr_q + 1'b1;
    end
  end

  // flush empties the store in one edge
  always_ff @(posedge clk) begin
    if (rst_n) begin
      raddr_q <= '0;
    end else if (jmp_flush_i) begin
      raddr_q <= waddr_q;
    end else if (pop) begin
      raddr_q <= raddr_q + 1'b1;
    end
  end

  // tag of the line at raddr_q, or of the next line to arrive when empty
  always_ff @(posedge clk) begin
    if (rst_n) begin
      head_tag_q <= RESET_PC[ADDR_W-1:LINE_OFF_W];
    end else if (jmp_flush_i) begin
      head_tag_q <= pc_tag;
    end else if (pop) begin
      head_tag_q <= head_tag_q + 1'b1;
    end
  end

  line_ram u_line_ram (
    .clk     (clk),
    .we_i    (wr_en),
    .waddr_i (waddr_q[FIFO_PTR_W-2:0]),
    .wdata_i (r_data_i),
    .raddr_i (raddr_q[FIFO_PTR_W-2:0]),
    .rdata_o (rd_line)
  );

  // ====================
  // instruction out
  // ====================

  // an empty store hits through the ram bypass when the line lands now
  assign inst_valid_o = !jmp_flush_i && tag_hit && (!empty || wr_en);

  always_comb begin
    inst_o = '0;
    if (inst_valid_o) begin
      case (pc_i[LINE_OFF_W-1:2])
        2'd0:    inst_o = rd_line[0*INST_W +: INST_W];
        2'd1:    inst_o = rd_line[1*INST_W +: INST_W];
        2'd2:    inst_o = rd_line[2*INST_W +: INST_W];
        default: inst_o = rd_line[3*INST_W +: INST_W];
      endcase
    end
  end

endmodule

//--- logic/pc_gen.sv
module pc_gen (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         redirect_i,
  input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc_i,
  input  logic                         inst_valid_i,
  output logic [fetch_pkg::ADDR_W-1:0] pc_o,
  output logic                         jmp_flush_o
);
  import fetch_pkg::*;

  logic [ADDR_W-1:0] pc_q;
  logic              flush_q;

  // ====================
  // fetch pc
  // ====================

  // a jump wins over the sequential step
  always_ff @(posedge clk) begin
    if (rst_n) begin
      pc_q <= RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (inst_valid_i) begin
      // one instruction consumed
      pc_q <= pc_q + ADDR_W'(INST_W / 8);
    end
  end

  // ====================
  // flush pulse
  // ====================

  // high for the single cycle in which the new target is on pc_o
  always_ff @(posedge clk) begin
    if (rst_n) begin
      flush_q <= 1'b0;
    end else begin
      flush_q <= redirect_i;
    end
  end

  assign pc_o        = pc_q;
  assign jmp_flush_o = flush_q;

endmodule

//--- logic/fetch_top.sv
module fetch_top (
  input  logic                         clk,
  input  logic                         rst_n,

  // jump from the execute stage
  input  logic                         redirect_i,
  input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc_i,

  // read address channel
  output logic                         ar_valid_o,
  input  logic                         ar_ready_i,
  output logic [fetch_pkg::ADDR_W-1:0] ar_addr_o,

  // read data channel
  input  logic                         r_valid_i,
  input  logic [fetch_pkg::LINE_W-1:0] r_data_i,
  output logic                         r_ready_o,

  // instruction stream to decode
  output logic                         inst_valid_o,
  output logic [fetch_pkg::INST_W-1:0] inst_o,
  output logic [fetch_pkg::ADDR_W-1:0] inst_pc_o
);
  import fetch_pkg::*;

  logic [ADDR_W-1:0] pc;
  logic              jmp_flush;
  logic              inst_valid;

  // ====================
  // pc sequencer
  // ====================

  pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .inst_valid_i  (inst_valid),
    .pc_o          (pc),
    .jmp_flush_o   (jmp_flush)
  );

  // ====================
  // line prefetch
  // ====================

  fetch_buffer u_fetch_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc),
    .jmp_flush_i  (jmp_flush),
    .ar_ready_i   (ar_ready_i),
    .ar_valid_o   (ar_valid_o),
    .ar_addr_o    (ar_addr_o),
    .r_valid_i    (r_valid_i),
    .r_data_i     (r_data_i),
    .r_ready_o    (r_ready_o),
    .inst_valid_o (inst_valid),
    .inst_o       (inst_o)
  );

  // decode sees the pc of every delivered word
  assign inst_valid_o = inst_valid;
  assign inst_pc_o    = pc;

endmodule

//--- tests/line_mem_model.sv
module line_mem_model (
  input  logic                         clk,
  input  logic                         rst_n,

  // read address channel
  input  logic                         ar_valid_i,
  input  logic [fetch_pkg::ADDR_W-1:0] ar_addr_i,
  output logic                         ar_ready_o,

  // read data channel
  output logic                         r_valid_o,
  output logic [fetch_pkg::LINE_W-1:0] r_data_o,
  input  logic                         r_ready_i,

  // random draw and stall level from the testbench
  input  logic [31:0]                  rnd_i,
  input  logic                         stall_i
);
  import fetch_pkg::*;

  logic [ADDR_W-1:0] line_addr;
  logic [1:0]        wait_cnt;

  // each word holds its own byte address xor a fixed key
  function automatic logic [LINE_W-1:0] line_at(input logic [ADDR_W-1:0] addr);
    logic [LINE_W-1:0] line;
    logic [ADDR_W-1:0] word_addr;
    int                i;
    line = '0;
    for (i = 0; i < LINE_W / INST_W; i++) begin
      word_addr = addr + ADDR_W'(4 * i);
      line[i*INST_W +: INST_W] = word_addr ^ 32'h5A5A_0000;
    end
    return line;
  endfunction

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_data_o   <= '0;
      wait_cnt   <= '0;
      line_addr  <= '0;
    end else begin
      // ready half the time, held low during a stall run
      ar_ready_o <= rnd_i[8] && !stall_i;
      if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
      end
      // data beat 1 to 4 cycles after the address beat
      if (ar_valid_i && ar_ready_o) begin
        line_addr <= ar_addr_i;
        if (rnd_i[1:0] == 2'd0) begin
          r_valid_o <= 1'b1;
          r_data_o  <= line_at(ar_addr_i);
        end else begin
          wait_cnt <= rnd_i[1:0];
        end
      end else if (wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
        if (wait_cnt == 2'd1) begin
          r_valid_o <= 1'b1;
          r_data_o  <= line_at(line_addr);
        end
      end
    end
  end

endmodule

//--- tests/tb_fetch.sv
module tb_fetch;
  import fetch_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int RUN_CYCLES      = 3000;
  localparam int WATCHDOG_CYCLES = RUN_CYCLES + 1000;
  localparam int MAX_GAP         = 50;
  localparam int STALL_LEN       = 30;
  localparam int STALL_GAP       = 64;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              redirect;
  logic [ADDR_W-1:0] redirect_pc;
  logic              ar_valid;
  logic              ar_ready;
  logic [ADDR_W-1:0] ar_addr;
  logic              r_valid;
  logic [LINE_W-1:0] r_data;
  logic              r_ready;
  logic              inst_valid;
  logic [INST_W-1:0] inst;
  logic [ADDR_W-1:0] inst_pc;

  // memory side stimulus
  logic [31:0] mem_rnd;
  logic        stall;
  logic [31:0] rng_state;
  int          stall_cnt;

  // reference state
  logic [ADDR_W-1:0] model_pc;
  logic              redirect_q;
  logic              outstanding;
  logic              stale;
  logic              first_ar_seen;
  int                idle_cycles;
  int                lines_held;
  bus_state_e        bus_view;

  fetch_top u_fetch_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .ar_valid_o    (ar_valid),
    .ar_ready_i    (ar_ready),
    .ar_addr_o     (ar_addr),
    .r_valid_i     (r_valid),
    .r_data_i      (r_data),
    .r_ready_o     (r_ready),
    .inst_valid_o  (inst_valid),
    .inst_o        (inst),
    .inst_pc_o     (inst_pc)
  );

  line_mem_model u_line_mem_model (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data),
    .r_ready_i  (r_ready),
    .rnd_i      (mem_rnd),
    .stall_i    (stall)
  );

  // ====================
  // helpers
  // ====================

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [ADDR_W-1:0] line_of(input logic [ADDR_W-1:0] addr);
    return {addr[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
  endfunction

  task automatic fail_now(input string what);
    $display("error at %0t: %s (model pc %h, bus %s)", $time, what, model_pc, bus_view.name());
    $display("Errors found");
    $fatal(1, "stopped at the first failing check");
  endtask

  // one set of random inputs per cycle
  task automatic drive_cycle();
    rng_state = xorshift32(rng_state);
    redirect <= (rng_state % 32'd40) == 32'd0;
    rng_state = xorshift32(rng_state);
    redirect_pc <= RESET_PC + (rng_state & 32'h0000_0FFC);
    rng_state = xorshift32(rng_state);
    mem_rnd <= rng_state;
    rng_state = xorshift32(rng_state);
    // stall run of STALL_LEN cycles, then a quiet gap before the next one
    if (stall_cnt != 0) begin
      stall_cnt = stall_cnt - 1;
    end else if (rng_state[6:0] == 7'd0) begin
      stall_cnt = STALL_LEN + STALL_GAP;
    end
    stall <= (stall_cnt > STALL_GAP);
  endtask

  task automatic check_cycle();
    logic ar_fire;
    logic r_fire;
    logic flush;
    ar_fire  = ar_valid && ar_ready;
    r_fire   = r_valid && r_ready;
    flush    = redirect_q;
    bus_view = outstanding ? BUS_WAIT_DATA : BUS_IDLE;

    // bus discipline
    if (ar_valid) begin
      assert (!outstanding) else fail_now("address beat raised while a read is outstanding");
      assert (ar_addr[LINE_OFF_W-1:0] == '0)
        else fail_now($sformatf("ar_addr %h is not line aligned", ar_addr));
      if (!first_ar_seen) begin
        assert (ar_addr == line_of(RESET_PC))
          else fail_now($sformatf("first ar_addr %h, expected %h", ar_addr, line_of(RESET_PC)));
        first_ar_seen = 1'b1;
      end
    end
    assert (!r_ready || outstanding) else fail_now("r_ready high with no read outstanding");

    // instruction stream
    if (flush) begin
      assert (!inst_valid) else fail_now("inst_valid high in the cycle after a redirect");
    end
    if (inst_valid) begin
      assert (inst_pc == model_pc)
        else fail_now($sformatf("inst_pc %h, expected %h", inst_pc, model_pc));
      assert (inst == (model_pc ^ 32'h5A5A_0000))
        else fail_now($sformatf("inst %h at pc %h, expected %h", inst, model_pc,
                                model_pc ^ 32'h5A5A_0000));
      idle_cycles = 0;
    end else begin
      idle_cycles = idle_cycles + 1;
      assert (idle_cycles < MAX_GAP)
        else fail_now($sformatf("no instruction for %0d cycles", idle_cycles));
    end

    // lines delivered but not yet left by the pc
    if (flush) begin
      lines_held = 0;
      if (outstanding && !r_fire) begin
        stale = 1'b1;
      end
    end else if (r_fire && !stale) begin
      lines_held = lines_held + 1;
    end
    if (r_fire) begin
      stale = 1'b0;
    end

    if (ar_fire) begin
      outstanding = 1'b1;
    end else if (r_fire) begin
      outstanding = 1'b0;
    end

    // pc model
    if (redirect) begin
      model_pc = redirect_pc;
    end else if (inst_valid) begin
      if (line_of(model_pc + 32'd4) != line_of(model_pc)) begin
        lines_held = lines_held - 1;
      end
      model_pc = model_pc + 32'd4;
    end
    assert (lines_held >= 0 && lines_held <= FIFO_DEPTH)
      else fail_now($sformatf("%0d lines held, at most %0d fit", lines_held, FIFO_DEPTH));
    redirect_q = redirect;
  endtask

  // ====================
  // clock, stimulus, checks
  // ====================

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n         = 1'b1;
    redirect      = 1'b0;
    redirect_pc   = RESET_PC;
    mem_rnd       = '0;
    stall         = 1'b0;
    rng_state     = 32'd24;
    stall_cnt     = 0;
    model_pc      = RESET_PC;
    redirect_q    = 1'b0;
    outstanding   = 1'b0;
    stale         = 1'b0;
    first_ar_seen = 1'b0;
    idle_cycles   = 0;
    lines_held    = 0;
    bus_view      = BUS_IDLE;
    repeat (3) @(posedge clk);
    rst_n <= 1'b0;
    repeat (RUN_CYCLES) begin
      @(posedge clk);
      drive_cycle();
    end
    @(posedge clk);
    $display("No errors");
    $finish;
  end

  // one check per cycle on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      assert (!ar_valid && !r_ready && !inst_valid)
        else fail_now("valid or ready output high during reset");
    end else begin
      check_cycle();
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the test did not reach its end in time");
    $display("Errors found");
    $fatal(1, "timeout");
  end

endmodule

//--- flist.f
common/fetch_pkg.sv
fetch_buffer/line_ram.sv
fetch_buffer/fetch_buffer.sv
logic/pc_gen.sv
logic/fetch_top.sv
tests/line_mem_model.sv
tests/tb_fetch.sv

//--- Makefile
SRCS := $(shell cat flist.f)

obj_dir/Vtb_fetch: flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_fetch \
		-Mdir obj_dir -f flist.f

.PHONY: run clean

run: obj_dir/Vtb_fetch
	@out="$$(./obj_dir/Vtb_fetch)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf obj_dir
